// File: hw/prof_macros.svh
`ifndef PROF_MACROS_SVH
`define PROF_MACROS_SVH

// Counter geometry
`define PROF_COUNT_W 32
`define PROF_NUM_CNT 20

// Bus ID width and the IDs the two caches issue with
`define PROF_AXI_ID_W  5
`define PROF_IC_AXI_ID 5'd0
`define PROF_DC_AXI_ID 5'd12

// Counter index map, stall slots are base plus reason code
`define PROF_SLOT_MCYCLE      0
`define PROF_SLOT_MINSTRET    1
`define PROF_SLOT_STALL_BASE  2
`define PROF_SLOT_IC_RD_CNT   14
`define PROF_SLOT_DC_RD_CNT   15
`define PROF_SLOT_DC_WR_CNT   16
`define PROF_SLOT_IC_RD_PEND  17
`define PROF_SLOT_DC_RD_PEND  18
`define PROF_SLOT_DC_WR_PEND  19

`endif

// File: hw/prof_pkg.sv
`include "prof_macros.svh"

package prof_pkg;

  // Issue stall reasons, lower code has higher priority
  typedef enum logic [3:0] {
    exception = 4'd0,
    csr_flush = 4'd1,
    amo_flush = 4'd2,
    br_miss   = 4'd3,
    fence     = 4'd4,
    sb_full   = 4'd5,
    br_haz    = 4'd6,
    raw_haz   = 4'd7,
    fu_busy   = 4'd8,
    iq_full   = 4'd9,
    ic_miss   = 4'd10,
    unknown   = 4'd11
  } stall_reason_e;

  // One counter value
  typedef logic [`PROF_COUNT_W-1:0] count_t;

  // Whole bank as seen by software
  typedef count_t [`PROF_NUM_CNT-1:0] count_bank_t;

  typedef logic [`PROF_AXI_ID_W-1:0] axi_id_t;

endpackage

// File: hw/prof_event_if.sv
`timescale 1ns/1ps
`include "prof_macros.svh"

interface prof_event_if
  import prof_pkg::*;
();

  // Issue stage outcome for this cycle
  logic          stall_v;
  logic          retire;
  stall_reason_e reason;

  // Bus traffic per cache stream
  logic ic_rd_start;
  logic dc_rd_start;
  logic dc_wr_start;
  logic ic_rd_pend;
  logic dc_rd_pend;
  logic dc_wr_pend;

  modport attr_mp (output stall_v, retire, reason);

  modport dma_mp (output ic_rd_start, dc_rd_start, dc_wr_start,
                  ic_rd_pend, dc_rd_pend, dc_wr_pend);

  modport bank_mp (input stall_v, retire, reason,
                   ic_rd_start, dc_rd_start, dc_wr_start,
                   ic_rd_pend, dc_rd_pend, dc_wr_pend);

endinterface

// File: hw/frontend_stall_tracker.sv
`timescale 1ns/1ps

module frontend_stall_tracker (
  input  logic clk_i,
  input  logic reset_i,
  input  logic iq_ready_i,
  input  logic ic_miss_i,
  input  logic ic_dresp_valid_i,
  output logic fe_iq_full_o,
  output logic fe_ic_miss_o
);

  logic miss_pend_r;

  // Outstanding I$ miss, held until the refill response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_pend_r <= 1'b0;
    end else if (ic_miss_i) begin
      miss_pend_r <= 1'b1;
    end else if (ic_dresp_valid_i) begin
      miss_pend_r <= 1'b0;
    end
  end

  // One stage between fetch and issue
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fe_iq_full_o <= 1'b0;
      fe_ic_miss_o <= 1'b0;
    end else begin
      fe_iq_full_o <= ~iq_ready_i;
      fe_ic_miss_o <= ic_miss_i | miss_pend_r;
    end
  end

  // Cache never answers in the cycle it reports a new miss
  a_miss_resp_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ic_miss_i && ic_dresp_valid_i));

endmodule

// File: hw/stall_attribution.sv
`timescale 1ns/1ps

module stall_attribution
  import prof_pkg::*;
(
  input  logic is_valid_i,
  input  logic is_ack_i,
  input  logic is_sb_full_i,
  input  logic is_unresolved_branch_i,
  input  logic is_ro_stall_i,
  input  logic is_fu_busy_i,
  input  logic flush_unissued_i,
  input  logic branch_mispredict_i,
  input  logic flush_amo_i,
  input  logic flush_csr_i,
  input  logic exception_i,
  input  logic iq_valid_i,
  input  logic fe_iq_full_i,
  input  logic fe_ic_miss_i,
  prof_event_if.attr_mp ev
);

  // One bit per reason code below unknown
  logic [unknown-1:0] cand_li;
  logic               retire_li;
  logic               issue_blk_li;
  logic               fe_empty_li;
  logic               other_flush_li;
  stall_reason_e      pick_li;

  assign retire_li = is_ack_i & ~flush_unissued_i;

  // Instruction waiting at issue but not accepted
  assign issue_blk_li = is_valid_i & ~is_ack_i;

  // Nothing at issue and nothing in the queue either
  assign fe_empty_li = ~is_valid_i & ~iq_valid_i;

  assign other_flush_li = exception_i | flush_csr_i | flush_amo_i | branch_mispredict_i;

  always_comb begin
    cand_li            = '0;
    cand_li[exception] = exception_i;
    cand_li[csr_flush] = flush_csr_i;
    cand_li[amo_flush] = flush_amo_i;
    cand_li[br_miss]   = branch_mispredict_i;
    cand_li[fence]     = flush_unissued_i & ~other_flush_li;
    cand_li[sb_full]   = issue_blk_li & is_sb_full_i;
    cand_li[br_haz]    = issue_blk_li & is_unresolved_branch_i;
    cand_li[raw_haz]   = issue_blk_li & is_ro_stall_i;
    cand_li[fu_busy]   = issue_blk_li & is_fu_busy_i;
    cand_li[iq_full]   = fe_empty_li & fe_iq_full_i;
    cand_li[ic_miss]   = fe_empty_li & fe_ic_miss_i;
  end

  // Walk from the lowest priority up so the lowest code lands last
  always_comb begin
    pick_li = unknown;
    for (int i = int'(unknown) - 1; i >= 0; i--) begin
      if (cand_li[i]) begin
        pick_li = stall_reason_e'(4'(i));
      end
    end
  end

  assign ev.retire  = retire_li;
  assign ev.stall_v = ~retire_li;
  assign ev.reason  = pick_li;

endmodule

// File: hw/dma_pending_tracker.sv
`timescale 1ns/1ps
`include "prof_macros.svh"

module dma_pending_tracker
  import prof_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    ar_valid_i,
  input  logic    ar_ready_i,
  input  axi_id_t ar_id_i,
  input  logic    r_valid_i,
  input  logic    r_last_i,
  input  axi_id_t r_id_i,
  input  logic    aw_valid_i,
  input  logic    aw_ready_i,
  input  axi_id_t aw_id_i,
  input  logic    b_valid_i,
  input  axi_id_t b_id_i,
  prof_event_if.dma_mp ev
);

  // Stream 0 is I$ read, 1 is D$ read and 2 is D$ write
  localparam int num_strm_lp = 3;

  logic [num_strm_lp-1:0] addr_v_li;
  logic [num_strm_lp-1:0] addr_acc_li;
  logic [num_strm_lp-1:0] end_li;
  logic [num_strm_lp-1:0] pend_r;
  logic [num_strm_lp-1:0] pend_lo;

  assign addr_v_li[0] = ar_valid_i & (ar_id_i == `PROF_IC_AXI_ID);
  assign addr_v_li[1] = ar_valid_i & (ar_id_i == `PROF_DC_AXI_ID);
  assign addr_v_li[2] = aw_valid_i & (aw_id_i == `PROF_DC_AXI_ID);

  assign addr_acc_li[1:0] = addr_v_li[1:0] & {2{ar_ready_i}};
  assign addr_acc_li[2]   = addr_v_li[2] & aw_ready_i;

  // Last read beat or write response closes the transfer
  assign end_li[0] = r_valid_i & r_last_i & (r_id_i == `PROF_IC_AXI_ID);
  assign end_li[1] = r_valid_i & r_last_i & (r_id_i == `PROF_DC_AXI_ID);
  assign end_li[2] = b_valid_i & (b_id_i == `PROF_DC_AXI_ID);

  // Set wins over end in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_r <= '0;
    end else begin
      pend_r <= addr_v_li | (pend_r & ~end_li);
    end
  end

  // New transfer shows pending in its own cycle
  assign pend_lo = addr_v_li | pend_r;

  assign ev.ic_rd_start = addr_acc_li[0];
  assign ev.dc_rd_start = addr_acc_li[1];
  assign ev.dc_wr_start = addr_acc_li[2];
  assign ev.ic_rd_pend  = pend_lo[0];
  assign ev.dc_rd_pend  = pend_lo[1];
  assign ev.dc_wr_pend  = pend_lo[2];

endmodule

// File: hw/event_counter_bank.sv
`timescale 1ns/1ps
`include "prof_macros.svh"

module event_counter_bank
  import prof_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          en_i,
  prof_event_if.bank_mp ev,
  output count_bank_t   counters_o
);

  localparam int num_stall_lp = int'(unknown) + 1;

  logic [`PROF_NUM_CNT-1:0] inc_li;
  count_bank_t              cnt_r;

  // Stall slots whose value differs between two snapshots
  function automatic logic [num_stall_lp-1:0] stall_moved(count_bank_t now_v,
                                                          count_bank_t old_v);
    logic [num_stall_lp-1:0] moved;
    for (int k = 0; k < num_stall_lp; k++) begin
      moved[k] = now_v[`PROF_SLOT_STALL_BASE + k] != old_v[`PROF_SLOT_STALL_BASE + k];
    end
    return moved;
  endfunction

  always_comb begin
    inc_li                                    = '0;
    inc_li[`PROF_SLOT_MCYCLE]                 = 1'b1;
    inc_li[`PROF_SLOT_MINSTRET]               = ev.retire;
    inc_li[`PROF_SLOT_STALL_BASE + ev.reason] = ev.stall_v;
    inc_li[`PROF_SLOT_IC_RD_CNT]              = ev.ic_rd_start;
    inc_li[`PROF_SLOT_DC_RD_CNT]              = ev.dc_rd_start;
    inc_li[`PROF_SLOT_DC_WR_CNT]              = ev.dc_wr_start;
    inc_li[`PROF_SLOT_IC_RD_PEND]             = ev.ic_rd_pend;
    inc_li[`PROF_SLOT_DC_RD_PEND]             = ev.dc_rd_pend;
    inc_li[`PROF_SLOT_DC_WR_PEND]             = ev.dc_wr_pend;
  end

  // Free running, wraps at full width
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r <= '0;
    end else if (en_i) begin
      for (int i = 0; i < `PROF_NUM_CNT; i++) begin
        if (inc_li[i]) begin
          cnt_r[i] <= cnt_r[i] + 1'b1;
        end
      end
    end
  end

  assign counters_o = cnt_r;

  a_one_stall_slot: assert property (@(posedge clk_i) disable iff (reset_i)
    (en_i && ev.stall_v) |=> $countones(stall_moved(cnt_r, $past(cnt_r))) == 1);

endmodule

// File: hw/core_profiler.sv
`timescale 1ns/1ps
`include "prof_macros.svh"

module core_profiler
  import prof_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        en_i,
  // Fetch side
  input  logic        iq_valid_i,
  input  logic        iq_ready_i,
  input  logic        ic_miss_i,
  input  logic        ic_dresp_valid_i,
  // Issue stage
  input  logic        is_valid_i,
  input  logic        is_ack_i,
  input  logic        is_sb_full_i,
  input  logic        is_unresolved_branch_i,
  input  logic        is_ro_stall_i,
  input  logic        is_fu_busy_i,
  // Flushes
  input  logic        flush_unissued_i,
  input  logic        branch_mispredict_i,
  input  logic        flush_amo_i,
  input  logic        flush_csr_i,
  input  logic        exception_i,
  // AXI master channels
  input  logic        ar_valid_i,
  input  logic        ar_ready_i,
  input  axi_id_t     ar_id_i,
  input  logic        r_valid_i,
  input  logic        r_last_i,
  input  axi_id_t     r_id_i,
  input  logic        aw_valid_i,
  input  logic        aw_ready_i,
  input  axi_id_t     aw_id_i,
  input  logic        b_valid_i,
  input  axi_id_t     b_id_i,
  output count_bank_t counters_o
);

  logic fe_iq_full_lo;
  logic fe_ic_miss_lo;

  prof_event_if ev_bus ();

  frontend_stall_tracker i_fe_tracker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .iq_ready_i      (iq_ready_i),
    .ic_miss_i       (ic_miss_i),
    .ic_dresp_valid_i(ic_dresp_valid_i),
    .fe_iq_full_o    (fe_iq_full_lo),
    .fe_ic_miss_o    (fe_ic_miss_lo)
  );

  stall_attribution i_stall_attr (
    .is_valid_i(is_valid_i), .is_ack_i(is_ack_i), .is_sb_full_i(is_sb_full_i),
    .is_unresolved_branch_i(is_unresolved_branch_i), .is_ro_stall_i(is_ro_stall_i),
    .is_fu_busy_i(is_fu_busy_i), .flush_unissued_i(flush_unissued_i),
    .branch_mispredict_i(branch_mispredict_i), .flush_amo_i(flush_amo_i),
    .flush_csr_i(flush_csr_i), .exception_i(exception_i), .iq_valid_i(iq_valid_i),
    .fe_iq_full_i(fe_iq_full_lo), .fe_ic_miss_i(fe_ic_miss_lo), .ev(ev_bus.attr_mp)
  );

  dma_pending_tracker i_dma_tracker (
    .clk_i(clk_i), .reset_i(reset_i),
    .ar_valid_i(ar_valid_i), .ar_ready_i(ar_ready_i), .ar_id_i(ar_id_i),
    .r_valid_i(r_valid_i), .r_last_i(r_last_i), .r_id_i(r_id_i),
    .aw_valid_i(aw_valid_i), .aw_ready_i(aw_ready_i), .aw_id_i(aw_id_i),
    .b_valid_i(b_valid_i), .b_id_i(b_id_i), .ev(ev_bus.dma_mp)
  );

  event_counter_bank i_cnt_bank (
    .clk_i(clk_i), .reset_i(reset_i), .en_i(en_i),
    .ev(ev_bus.bank_mp), .counters_o(counters_o)
  );

endmodule

// File: bench/core_profiler_tb.sv
`timescale 1ns/1ps
`include "prof_macros.svh"

module core_profiler_tb
  import prof_pkg::*;
();

  localparam int timeout_lp = 3000;

  logic clk_i, reset_i, en_i;
  logic iq_valid_i, iq_ready_i, ic_miss_i, ic_dresp_valid_i;
  logic is_valid_i, is_ack_i, is_sb_full_i, is_unresolved_branch_i;
  logic is_ro_stall_i, is_fu_busy_i;
  logic flush_unissued_i, branch_mispredict_i, flush_amo_i, flush_csr_i, exception_i;
  logic ar_valid_i, ar_ready_i, r_valid_i, r_last_i, aw_valid_i, aw_ready_i, b_valid_i;
  axi_id_t ar_id_i, r_id_i, aw_id_i, b_id_i;
  count_bank_t counters_o;

  count_bank_t exp_cnt;
  logic        m_miss_pend, m_fe_full, m_fe_miss;
  logic [2:0]  m_dma_pend;
  integer      seed = 59;
  int          err_cnt = 0;
  int          cycle_cnt = 0;
  string       test_name = "reset";

  core_profiler i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Reference model, follows the profiler rules one edge at a time
  always @(posedge clk_i) begin : ref_model
    count_bank_t nxt;
    logic [2:0]  av, ed;
    logic        ret, blk, fe_empty;
    int          rsn;
    av[0] = ar_valid_i && ar_id_i == `PROF_IC_AXI_ID;
    av[1] = ar_valid_i && ar_id_i == `PROF_DC_AXI_ID;
    av[2] = aw_valid_i && aw_id_i == `PROF_DC_AXI_ID;
    ed[0] = r_valid_i && r_last_i && r_id_i == `PROF_IC_AXI_ID;
    ed[1] = r_valid_i && r_last_i && r_id_i == `PROF_DC_AXI_ID;
    ed[2] = b_valid_i && b_id_i == `PROF_DC_AXI_ID;
    ret = is_ack_i && !flush_unissued_i;
    blk = is_valid_i && !is_ack_i;
    fe_empty = !is_valid_i && !iq_valid_i;
    if (exception_i) rsn = 0;
    else if (flush_csr_i) rsn = 1;
    else if (flush_amo_i) rsn = 2;
    else if (branch_mispredict_i) rsn = 3;
    else if (flush_unissued_i) rsn = 4;
    else if (blk && is_sb_full_i) rsn = 5;
    else if (blk && is_unresolved_branch_i) rsn = 6;
    else if (blk && is_ro_stall_i) rsn = 7;
    else if (blk && is_fu_busy_i) rsn = 8;
    else if (fe_empty && m_fe_full) rsn = 9;
    else if (fe_empty && m_fe_miss) rsn = 10;
    else rsn = 11;
    nxt = exp_cnt;
    nxt[`PROF_SLOT_MCYCLE] = nxt[`PROF_SLOT_MCYCLE] + 1;
    if (ret) nxt[`PROF_SLOT_MINSTRET] = nxt[`PROF_SLOT_MINSTRET] + 1;
    else nxt[`PROF_SLOT_STALL_BASE + rsn] = nxt[`PROF_SLOT_STALL_BASE + rsn] + 1;
    nxt[`PROF_SLOT_IC_RD_CNT] = nxt[`PROF_SLOT_IC_RD_CNT] + (av[0] && ar_ready_i);
    nxt[`PROF_SLOT_DC_RD_CNT] = nxt[`PROF_SLOT_DC_RD_CNT] + (av[1] && ar_ready_i);
    nxt[`PROF_SLOT_DC_WR_CNT] = nxt[`PROF_SLOT_DC_WR_CNT] + (av[2] && aw_ready_i);
    nxt[`PROF_SLOT_IC_RD_PEND] = nxt[`PROF_SLOT_IC_RD_PEND] + (av[0] || m_dma_pend[0]);
    nxt[`PROF_SLOT_DC_RD_PEND] = nxt[`PROF_SLOT_DC_RD_PEND] + (av[1] || m_dma_pend[1]);
    nxt[`PROF_SLOT_DC_WR_PEND] = nxt[`PROF_SLOT_DC_WR_PEND] + (av[2] || m_dma_pend[2]);
    if (reset_i) begin
      exp_cnt <= '0;
      m_miss_pend <= 1'b0;
      m_fe_full <= 1'b0;
      m_fe_miss <= 1'b0;
      m_dma_pend <= '0;
    end else begin
      if (en_i) exp_cnt <= nxt;
      m_miss_pend <= ic_miss_i ? 1'b1 : (ic_dresp_valid_i ? 1'b0 : m_miss_pend);
      m_fe_full <= !iq_ready_i;
      m_fe_miss <= ic_miss_i || m_miss_pend;
      m_dma_pend <= av | (m_dma_pend & ~ed);
    end
  end

  // One check per counter slot
  for (genvar g = 0; g < `PROF_NUM_CNT; g++) begin : g_chk
    a_cnt: assert property (@(posedge clk_i) disable iff (reset_i) counters_o[g] == exp_cnt[g])
      else begin
        err_cnt++;
        $display("FAILED %s slot %0d: expected %0d actual %0d", test_name, g,
                 $sampled(exp_cnt[g]), $sampled(counters_o[g]));
      end
  end

  // Mostly cache IDs, with some foreign ones
  function automatic axi_id_t pick_id(logic [1:0] sel, logic [4:0] any);
    case (sel)
      2'd0:    return `PROF_IC_AXI_ID;
      2'd1:    return `PROF_DC_AXI_ID;
      2'd2:    return 5'd7;
      default: return any;
    endcase
  endfunction

  // Modes: 0 en gate, 1 retire, 2 flush, 3 hazard, 4 frontend, 5 dma, 6 mixed
  task automatic drive_cycle(input int mode);
    logic [31:0] r, q, s;
    logic        miss, flush_on, haz_on, dma_on;
    r = $random(seed);
    q = $random(seed);
    s = $random(seed);
    flush_on = mode inside {0, 2, 6};
    haz_on = mode inside {0, 3, 6};
    dma_on = mode inside {0, 5, 6};
    miss = (mode == 4) ? &r[13:11] : &r[15:11];
    @(posedge clk_i);
    en_i <= (mode == 0) ? r[0] : ((mode == 6) ? |r[3:1] : 1'b1);
    is_valid_i <= (mode == 3) ? 1'b1 : ((mode == 4) ? 1'b0 : r[4]);
    is_ack_i <= (mode == 3) ? &r[7:5] : ((mode == 4) ? 1'b0 : ((mode == 2) ? &r[6:5] : r[5]));
    iq_valid_i <= (mode == 4) ? &r[9:8] : r[8];
    iq_ready_i <= r[10];
    ic_miss_i <= miss;
    ic_dresp_valid_i <= !miss && (&r[17:16]);
    flush_unissued_i <= (mode == 1) ? &r[19:18] : (flush_on && r[18]);
    branch_mispredict_i <= flush_on && (&q[1:0]);
    flush_amo_i <= flush_on && (&q[3:2]);
    flush_csr_i <= flush_on && (&q[5:4]);
    exception_i <= flush_on && (&q[7:6]);
    is_sb_full_i <= haz_on && r[20];
    is_unresolved_branch_i <= haz_on && r[21];
    is_ro_stall_i <= haz_on && r[22];
    is_fu_busy_i <= haz_on && r[23];
    ar_valid_i <= dma_on && q[8];
    ar_ready_i <= q[9];
    ar_id_i <= pick_id(q[11:10], s[4:0]);
    r_valid_i <= dma_on && q[12];
    r_last_i <= q[13];
    r_id_i <= pick_id(q[15:14], s[9:5]);
    aw_valid_i <= dma_on && q[16];
    aw_ready_i <= q[17];
    aw_id_i <= pick_id(q[19:18], s[14:10]);
    b_valid_i <= dma_on && q[20];
    b_id_i <= pick_id(q[22:21], s[19:15]);
  endtask

  task automatic run_phase(input string name, input int mode, input int cycles);
    test_name = name;
    repeat (cycles) drive_cycle(mode);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_lp) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_lp);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    reset_i = 1'b1;
    {en_i, iq_valid_i, iq_ready_i, ic_miss_i, ic_dresp_valid_i} = '0;
    {is_valid_i, is_ack_i, is_sb_full_i, is_unresolved_branch_i} = '0;
    {is_ro_stall_i, is_fu_busy_i, flush_unissued_i, branch_mispredict_i} = '0;
    {flush_amo_i, flush_csr_i, exception_i} = '0;
    {ar_valid_i, ar_ready_i, r_valid_i, r_last_i, aw_valid_i, aw_ready_i, b_valid_i} = '0;
    {ar_id_i, r_id_i, aw_id_i, b_id_i} = '0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    run_phase("en_gate", 0, 200);
    run_phase("retire", 1, 200);
    run_phase("flush_prio", 2, 200);
    run_phase("issue_hazard", 3, 200);
    run_phase("frontend", 4, 200);
    run_phase("dma", 5, 200);
    run_phase("mixed", 6, 200);
    // Let the last edges get checked
    repeat (3) @(posedge clk_i);
    $display("Closing report: %0d errors in %0d cycles", err_cnt, cycle_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hw
hw/prof_pkg.sv
hw/prof_event_if.sv
hw/frontend_stall_tracker.sv
hw/stall_attribution.sv
hw/dma_pending_tracker.sv
hw/event_counter_bank.sv
hw/core_profiler.sv
bench/core_profiler_tb.sv
